/* rtl/psgBusPkg.sv */
package psgBusPkg;

	// ========================================
	// shared sample memory
	// ========================================
	localparam int SAMPLE_ADDR_W = 8;
	localparam int SAMPLE_W = 8;

	typedef logic [SAMPLE_ADDR_W-1:0] sampleAddrT;
	typedef logic signed [SAMPLE_W-1:0] sampleT;

	// requesters on the memory bus, grant index width follows
	localparam int MAX_VOICES = 8;
	localparam int VOICE_IDX_W = $clog2(MAX_VOICES);

	// ========================================
	// host write port
	// ========================================
	localparam int HOST_ADDR_W = 10;
	localparam int HOST_DATA_W = 16;

	typedef logic [HOST_ADDR_W-1:0] hostAddrT;
	typedef logic [HOST_DATA_W-1:0] hostDataT;

	// top address bit: 0 = sample memory, 1 = voice registers
	localparam int HOST_REG_SEL = HOST_ADDR_W - 1;
	// voice number sits above the two register offset bits
	localparam int HOST_VOICE_LSB = 2;

endpackage

/* rtl/psgVoicePkg.sv */
package psgVoicePkg;

	// phase accumulator, upper bits form the table index
	localparam int FREQ_W = 16;
	localparam int PHASE_W = 24;

	typedef logic [FREQ_W-1:0] freqT;
	typedef logic [PHASE_W-1:0] phaseT;
	typedef logic [3:0] volumeT;
	// wave length is 2 << lenLog2 samples
	typedef logic [2:0] lenLog2T;

	// ========================================
	// mixer output range
	// ========================================
	localparam int MIX_W = 10;
	typedef logic signed [MIX_W-1:0] mixT;
	localparam int MIX_MAX = 2 ** (MIX_W - 1) - 1;
	localparam int MIX_MIN = -(2 ** (MIX_W - 1));
	// product of sample and volume is brought back to sample scale
	localparam int VOL_SHIFT = 4;

	// register offsets inside one voice window
	localparam logic [1:0] REG_FREQ = 2'd0;
	localparam logic [1:0] REG_BASE = 2'd1;
	localparam logic [1:0] REG_CTRL = 2'd2;

	// control word fields
	localparam int CTRL_GATE = 0;
	localparam int CTRL_VOL_LSB = 4;
	localparam int CTRL_LEN_LSB = 8;

endpackage

/* rtl/psgBusArb.sv */
module psgBusArb import psgBusPkg::*; #(
	parameter int numVoices = 8
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic ack,
	input logic [numVoices-1:0] req,
	output logic [numVoices-1:0] sel,
	output logic [VOICE_IDX_W-1:0] seln
);

	logic [numVoices-1:0] winSel;
	logic [VOICE_IDX_W-1:0] winIdx;
	logic anyReq;

	// ========================================
	// fixed priority, voice 0 wins
	// ========================================
	always_comb begin
		winSel = '0;
		winIdx = '0;
		anyReq = 1'b0;
		for (int i = 0; i < numVoices; i++) begin
			if (req[i] && !anyReq) begin
				winSel[i] = 1'b1;
				winIdx = VOICE_IDX_W'(i);
				anyReq = 1'b1;
			end
		end
	end

	// re-arbitrate only on an enabled cycle with the bus done or idle
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end
		else if (ce && ack && anyReq) begin
			sel <= winSel;
			seln <= winIdx;
		end
		// otherwise the last owner keeps the bus
	end

endmodule

/* rtl/psgWaveVoice.sv */
module psgWaveVoice import psgBusPkg::*, psgVoicePkg::*; (
	input logic clk,
	input logic rst,
	input logic ce,
	input freqT freq,
	input sampleAddrT base,
	input lenLog2T lenLog2,
	input logic gate,
	input logic grant,
	input logic ack,
	input sampleT memData,
	output logic fetchReq,
	output sampleAddrT fetchAddr,
	output sampleT sample
);

	phaseT phase;
	phaseT nextPhase;
	sampleAddrT curIdx;
	sampleAddrT nextIdx;
	logic [SAMPLE_ADDR_W:0] lenSpan;
	sampleAddrT lenMask;
	logic gateQ;
	logic gateRise;
	logic idxStep;
	logic served;

	// ========================================
	// phase and table address
	// ========================================
	assign nextPhase = phase + phaseT'(freq);
	assign curIdx = phase[PHASE_W-1 -: SAMPLE_ADDR_W];
	assign nextIdx = nextPhase[PHASE_W-1 -: SAMPLE_ADDR_W];

	// 2 to 256 samples, table index wraps inside the wave
	assign lenSpan = (SAMPLE_ADDR_W + 1)'(2) << lenLog2;
	assign lenMask = sampleAddrT'(lenSpan - 1'b1);
	assign fetchAddr = base + (curIdx & lenMask);

	// ========================================
	// fetch request
	// ========================================
	assign gateRise = gate && !gateQ;
	assign idxStep = ce && gate && (nextIdx != curIdx);
	// data is ours only while we still ask for it
	assign served = grant && ack && fetchReq;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
			gateQ <= 1'b0;
			fetchReq <= 1'b0;
			sample <= '0;
		end
		else begin
			gateQ <= gate;
			if (!gate) begin
				// voice silent, restart from the first entry on next gate
				phase <= '0;
				fetchReq <= 1'b0;
				sample <= '0;
			end
			else begin
				if (ce)
					phase <= nextPhase;
				if (served)
					sample <= memData;
				// a new step wins over completion, the request then picks up
				// the latest address and older steps are skipped
				if (gateRise || idxStep)
					fetchReq <= 1'b1;
				else if (served)
					fetchReq <= 1'b0;
			end
		end
	end

endmodule

/* rtl/psgSampleMem.sv */
module psgSampleMem import psgBusPkg::*; #(
	parameter int numVoices = 8
) (
	input logic clk,
	input logic rst,
	input logic we,
	input sampleAddrT wrAddr,
	input sampleT wrData,
	input sampleAddrT [numVoices-1:0] rdAddr,
	input logic [numVoices-1:0] req,
	input logic [VOICE_IDX_W-1:0] seln,
	output sampleT rdData,
	output logic ack
);

	sampleT mem [2**SAMPLE_ADDR_W];

	logic reqSel;
	sampleAddrT addrSel;
	logic readNow;
	// read data valid, ack pulse
	logic pulse;
	// one quiet cycle after each pulse
	logic recover;

	assign reqSel = req[seln];
	assign addrSel = rdAddr[seln];

	// one read per grant; the recover cycle lets the requester drop its level
	// before a second read could start
	assign readNow = reqSel && !pulse && !recover;

	// high on completion, or when the owner has nothing to ask for
	assign ack = pulse || !reqSel;

	// ========================================
	// storage
	// ========================================
	always_ff @(posedge clk) begin
		if (we)
			mem[wrAddr] <= wrData;
		if (readNow)
			rdData <= mem[addrSel];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pulse <= 1'b0;
			recover <= 1'b0;
		end
		else begin
			pulse <= readNow;
			recover <= pulse;
		end
	end

endmodule

/* rtl/psgRegs.sv */
module psgRegs import psgBusPkg::*, psgVoicePkg::*; #(
	parameter int numVoices = 8
) (
	input logic clk,
	input logic rst,
	input logic we,
	input hostAddrT addr,
	input hostDataT data,
	output freqT [numVoices-1:0] freq,
	output sampleAddrT [numVoices-1:0] base,
	output lenLog2T [numVoices-1:0] lenLog2,
	output volumeT [numVoices-1:0] vol,
	output logic [numVoices-1:0] gate
);

	logic regWe;
	logic [VOICE_IDX_W-1:0] voiceSel;
	logic [1:0] regSel;

	// ========================================
	// address decode
	// ========================================
	assign regWe = we && addr[HOST_REG_SEL];
	assign voiceSel = addr[HOST_VOICE_LSB +: VOICE_IDX_W];
	assign regSel = addr[HOST_VOICE_LSB-1:0];

	// voices past numVoices have no slot, so writes there fall through
	always_ff @(posedge clk) begin
		if (rst) begin
			freq <= '0;
			base <= '0;
			lenLog2 <= '0;
			vol <= '0;
			gate <= '0;
		end
		else if (regWe) begin
			for (int i = 0; i < numVoices; i++) begin
				if (voiceSel == VOICE_IDX_W'(i)) begin
					case (regSel)
						REG_FREQ: begin
							freq[i] <= freqT'(data);
						end
						REG_BASE: begin
							base[i] <= data[SAMPLE_ADDR_W-1:0];
						end
						REG_CTRL: begin
							gate[i] <= data[CTRL_GATE];
							vol[i] <= data[CTRL_VOL_LSB +: $bits(volumeT)];
							lenLog2[i] <= data[CTRL_LEN_LSB +: $bits(lenLog2T)];
						end
						// offset 3 is unused
						default: begin
						end
					endcase
				end
			end
		end
	end

endmodule

/* rtl/psgMixer.sv */
module psgMixer import psgBusPkg::*, psgVoicePkg::*; #(
	parameter int numVoices = 8
) (
	input logic clk,
	input logic rst,
	input sampleT [numVoices-1:0] sample,
	input volumeT [numVoices-1:0] vol,
	output mixT mixOut
);

	localparam int prodW = SAMPLE_W + $bits(volumeT) + 1;
	// headroom for MAX_VOICES full-scale voices
	localparam int sumW = prodW + VOICE_IDX_W;

	logic signed [prodW-1:0] prod [numVoices];
	logic signed [sumW-1:0] sum;

	// ========================================
	// scale and sum
	// ========================================
	always_comb begin
		sum = '0;
		for (int i = 0; i < numVoices; i++) begin
			// volume is unsigned, zero-extend before the signed multiply
			prod[i] = sample[i] * $signed({1'b0, vol[i]});
			sum = sum + (prod[i] >>> VOL_SHIFT);
		end
	end

	// clamp to the output range
	always_ff @(posedge clk) begin
		if (rst)
			mixOut <= '0;
		else if (sum > MIX_MAX)
			mixOut <= mixT'(MIX_MAX);
		else if (sum < MIX_MIN)
			mixOut <= mixT'(MIX_MIN);
		else
			mixOut <= mixT'(sum);
	end

endmodule

/* rtl/psgWaveSys.sv */
module psgWaveSys import psgBusPkg::*, psgVoicePkg::*; #(
	parameter int numVoices = 8
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic hostWe,
	input hostAddrT hostAddr,
	input hostDataT hostData,
	output mixT mixOut,
	output logic [numVoices-1:0] busGrant,
	output logic [VOICE_IDX_W-1:0] busOwner
);

	freqT [numVoices-1:0] voiceFreq;
	sampleAddrT [numVoices-1:0] voiceBase;
	lenLog2T [numVoices-1:0] voiceLen;
	volumeT [numVoices-1:0] voiceVol;
	logic [numVoices-1:0] voiceGate;

	logic [numVoices-1:0] fetchReq;
	sampleAddrT [numVoices-1:0] fetchAddr;
	sampleT [numVoices-1:0] voiceSample;

	sampleT memData;
	logic memAck;

	// ========================================
	// host side
	// ========================================
	psgRegs #(
		.numVoices(numVoices)
	) psgRegs_i (
		.clk(clk),
		.rst(rst),
		.we(hostWe),
		.addr(hostAddr),
		.data(hostData),
		.freq(voiceFreq),
		.base(voiceBase),
		.lenLog2(voiceLen),
		.vol(voiceVol),
		.gate(voiceGate)
	);

	// ========================================
	// voices and the shared memory bus
	// ========================================
	for (genvar v = 0; v < numVoices; v++) begin : voiceGen
		psgWaveVoice psgWaveVoice_i (
			.clk(clk),
			.rst(rst),
			.ce(ce),
			.freq(voiceFreq[v]),
			.base(voiceBase[v]),
			.lenLog2(voiceLen[v]),
			.gate(voiceGate[v]),
			.grant(busGrant[v]),
			.ack(memAck),
			.memData(memData),
			.fetchReq(fetchReq[v]),
			.fetchAddr(fetchAddr[v]),
			.sample(voiceSample[v])
		);
	end

	psgBusArb #(
		.numVoices(numVoices)
	) psgBusArb_i (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.ack(memAck),
		.req(fetchReq),
		.sel(busGrant),
		.seln(busOwner)
	);

	// low half of the host map loads samples
	psgSampleMem #(
		.numVoices(numVoices)
	) psgSampleMem_i (
		.clk(clk),
		.rst(rst),
		.we(hostWe && !hostAddr[HOST_REG_SEL]),
		.wrAddr(hostAddr[SAMPLE_ADDR_W-1:0]),
		.wrData(sampleT'(hostData[SAMPLE_W-1:0])),
		.rdAddr(fetchAddr),
		.req(fetchReq),
		.seln(busOwner),
		.rdData(memData),
		.ack(memAck)
	);

	psgMixer #(
		.numVoices(numVoices)
	) psgMixer_i (
		.clk(clk),
		.rst(rst),
		.sample(voiceSample),
		.vol(voiceVol),
		.mixOut(mixOut)
	);

endmodule

/* testbench/psgWaveSysTable.svh */
`ifndef PSG_WAVE_SYS_TABLE_SVH
`define PSG_WAVE_SYS_TABLE_SVH

// ========================================
// test kinds and sample memory layout
// ========================================
localparam int KIND_RESET = 0;
localparam int KIND_SINGLE = 1;
localparam int KIND_PRIO = 2;
localparam int KIND_HOLD = 3;
localparam int KIND_SAT = 4;
localparam int KIND_STEP = 5;

// random samples fill the lowest words, fixed ones sit further up
localparam int RAND_WORDS = 16;
localparam int SAT_HIGH = 'h20;
localparam int SAT_LOW = 'h21;
localparam int STEP_BASE = 'h40;
localparam int STEP_VOL = 15;
localparam int STEP_WORDS = 4;
// six values cover the wrap back to the first entry
localparam int STEP_VALUES = 6;
// host write cycles one entry may spend before its settle count
localparam int WRITE_BUDGET = 80;

typedef struct packed {
	int kind;
	int voice;
	int base;
	int vol;
	int freq;
	int lenLog2;
	int settle;
	int expGrant;
} testEntryT;

localparam int NUM_TESTS = 8;

// kind, voice, base, volume, freq, lenLog2, settle cycles, expected grant
localparam testEntryT TEST_TABLE [NUM_TESTS] = '{
	'{KIND_RESET, 0, 0, 0, 0, 0, 4, 0},
	'{KIND_SINGLE, 5, 'h07, 9, 0, 0, 40, 0},
	// voice 0 is left as bus owner for the priority entry
	'{KIND_SINGLE, 0, 'h0c, 15, 0, 0, 40, 0},
	'{KIND_PRIO, 0, 0, 4, 0, 0, 160, 0},
	// the priority entry ends with voice 7 owning the bus
	'{KIND_HOLD, 1, 0, 4, 0, 0, 60, 'h80},
	'{KIND_SAT, 0, SAT_HIGH, 15, 0, 0, 120, 0},
	'{KIND_SAT, 0, SAT_LOW, 15, 0, 0, 120, 0},
	// one table step every four ce cycles over a 4-sample wave
	'{KIND_STEP, 3, STEP_BASE, STEP_VOL, 16384, 1, 160, 0}
};

// sample times volume, arithmetic shift right by 4
function automatic int scaledSample(input int smp, input int vol);
	return (smp * vol) >>> 4;
endfunction

// expected mixer output for a set of voice samples and volumes
function automatic int mixModel(input int smp [NUM_VOICES], input int vol [NUM_VOICES]);
	int acc;
	acc = 0;
	for (int i = 0; i < NUM_VOICES; i++)
		acc += scaledSample(smp[i], vol[i]);
	if (acc > MIX_MAX)
		acc = MIX_MAX;
	else if (acc < MIX_MIN)
		acc = MIX_MIN;
	return acc;
endfunction

function automatic int runLimit();
	int total;
	total = 200;
	for (int i = 0; i < NUM_TESTS; i++)
		total += TEST_TABLE[i].settle + WRITE_BUDGET;
	return total;
endfunction

`endif

/* testbench/psgWaveSysTb.sv */
module psgWaveSysTb import psgBusPkg::*, psgVoicePkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_VOICES = 8;

	`include "psgWaveSysTable.svh"

	logic clk;
	logic rst;
	logic ce = 1'b0;
	logic hostWe;
	hostAddrT hostAddr;
	hostDataT hostData;
	mixT mixOut;
	logic [NUM_VOICES-1:0] busGrant;
	logic [VOICE_IDX_W-1:0] busOwner;

	logic ceEnable = 1'b1;
	logic [1:0] ceCount = 2'd0;
	int cycleCount = 0;
	int cycleLimit;
	int seed;
	int memModel [2**SAMPLE_ADDR_W];

	psgWaveSys #(
		.numVoices(NUM_VOICES)
	) psgWaveSys_i (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.mixOut(mixOut),
		.busGrant(busGrant),
		.busOwner(busOwner)
	);

	// ========================================
	// clock, voice rate enable, timeout
	// ========================================
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// one cycle in four while enabled
	always @(posedge clk) begin
		ceCount <= ceCount + 2'd1;
		ce <= ceEnable && (ceCount == 2'd3);
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Run did not finish within %0d clock cycles", cycleLimit);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	// ========================================
	// helpers
	// ========================================
	task automatic checkValue(input logic signed [31:0] actual,
			input logic signed [31:0] expected, input string what);
		if (actual !== expected) begin
			$display("Error at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic hostWrite(input hostAddrT addr, input hostDataT data);
		@(posedge clk);
		hostWe <= 1'b1;
		hostAddr <= addr;
		hostData <= data;
		@(posedge clk);
		hostWe <= 1'b0;
	endtask

	function automatic hostAddrT regAddr(input int voice, input logic [1:0] offset);
		hostAddrT a;
		a = '0;
		a[HOST_REG_SEL] = 1'b1;
		a[HOST_VOICE_LSB +: VOICE_IDX_W] = VOICE_IDX_W'(voice);
		a[1:0] = offset;
		return a;
	endfunction

	task automatic writeSample(input int addr, input int smp);
		hostWrite(hostAddrT'(addr), hostDataT'(smp & 'hff));
		memModel[addr] = smp;
	endtask

	task automatic setupVoice(input int v, input int base, input int freq, input int vol,
			input int len);
		hostWrite(regAddr(v, REG_FREQ), hostDataT'(freq));
		hostWrite(regAddr(v, REG_BASE), hostDataT'(base));
		// gate in bit 0, volume in 7:4, lenLog2 in 10:8
		hostWrite(regAddr(v, REG_CTRL), hostDataT'((len << 8) | (vol << 4) | 1));
	endtask

	task automatic silenceAll();
		for (int v = 0; v < NUM_VOICES; v++)
			hostWrite(regAddr(v, REG_CTRL), '0);
	endtask

	task automatic loadSamples();
		logic signed [7:0] smp;
		int scaled;
		logic fresh;
		for (int a = 0; a < RAND_WORDS; a++) begin
			smp = 8'($random(seed));
			writeSample(a, smp);
		end
		writeSample(SAT_HIGH, 127);
		writeSample(SAT_LOW, -128);
		// step entries need distinct nonzero mix values to be told apart
		for (int k = 0; k < STEP_WORDS; k++) begin
			fresh = 1'b0;
			while (!fresh) begin
				smp = 8'($random(seed));
				scaled = scaledSample(smp, STEP_VOL);
				fresh = (scaled != 0);
				for (int j = 0; j < k; j++)
					if (scaledSample(memModel[STEP_BASE + j], STEP_VOL) == scaled)
						fresh = 1'b0;
			end
			writeSample(STEP_BASE + k, smp);
		end
	endtask

	// ========================================
	// watchers for sequences
	// ========================================
	task automatic watchOwners(input int settle);
		logic [NUM_VOICES-1:0] lastGrant;
		int seen;
		int cycles;
		// voice 0 holds the bus first and the pending voices follow in ascending order
		@(negedge clk);
		lastGrant = busGrant;
		checkValue(busOwner, 0, "first bus owner");
		checkValue(busGrant, 1, "first bus grant");
		seen = 1;
		cycles = 0;
		while (seen < NUM_VOICES && cycles < settle) begin
			@(negedge clk);
			cycles++;
			if (busGrant != lastGrant) begin
				lastGrant = busGrant;
				checkValue(busOwner, seen, "bus owner order");
				checkValue(busGrant, 1 << seen, "bus grant order");
				seen++;
			end
		end
		checkValue(seen, NUM_VOICES, "number of bus owners seen");
	endtask

	task automatic watchSteps(input testEntryT t);
		int seen [$];
		int smp [NUM_VOICES];
		int vol [NUM_VOICES];
		int last;
		int cycles;
		int len;
		len = 2 << t.lenLog2;
		@(negedge clk);
		last = mixOut;
		cycles = 0;
		while (seen.size() < STEP_VALUES && cycles < t.settle) begin
			@(negedge clk);
			cycles++;
			if (mixOut != last) begin
				last = mixOut;
				seen.push_back(last);
			end
		end
		checkValue(seen.size(), STEP_VALUES, "number of stepped mix values");
		for (int k = 0; k < STEP_VALUES; k++) begin
			smp = '{default: 0};
			vol = '{default: 0};
			smp[t.voice] = memModel[t.base + k % len];
			vol[t.voice] = t.vol;
			checkValue(seen[k], mixModel(smp, vol), "stepped mix value");
		end
	endtask

	// ========================================
	// one table entry
	// ========================================
	task automatic runEntry(input testEntryT t);
		int smp [NUM_VOICES];
		int vol [NUM_VOICES];
		smp = '{default: 0};
		vol = '{default: 0};
		case (t.kind)
			KIND_RESET: begin
				repeat (t.settle) @(posedge clk);
				@(negedge clk);
				checkValue(mixOut, 0, "mixOut after reset");
				checkValue(busGrant, 0, "busGrant after reset");
			end
			KIND_SINGLE: begin
				silenceAll();
				setupVoice(t.voice, t.base, t.freq, t.vol, t.lenLog2);
				repeat (t.settle) @(posedge clk);
				@(negedge clk);
				smp[t.voice] = memModel[t.base];
				vol[t.voice] = t.vol;
				checkValue(mixOut, mixModel(smp, vol), "single voice mix");
			end
			KIND_PRIO: begin
				silenceAll();
				// all voices ask before the arbiter may move
				ceEnable <= 1'b0;
				for (int v = 0; v < NUM_VOICES; v++)
					setupVoice(v, t.base + v, 0, t.vol, 0);
				ceEnable <= 1'b1;
				watchOwners(t.settle);
			end
			KIND_HOLD: begin
				silenceAll();
				ceEnable <= 1'b0;
				for (int v = t.voice; v < t.voice + 3; v++) begin
					setupVoice(v, t.base + v, 0, t.vol, 0);
					@(negedge clk);
					checkValue(busGrant, t.expGrant, "busGrant with ce low");
				end
				hostWrite(regAddr(t.voice + 1, REG_CTRL), '0);
				repeat (t.settle) begin
					@(negedge clk);
					checkValue(busGrant, t.expGrant, "busGrant with ce low");
				end
				@(posedge clk);
				ceEnable <= 1'b1;
			end
			KIND_SAT: begin
				silenceAll();
				for (int v = 0; v < NUM_VOICES; v++) begin
					setupVoice(v, t.base, t.freq, t.vol, t.lenLog2);
					smp[v] = memModel[t.base];
					vol[v] = t.vol;
				end
				repeat (t.settle) @(posedge clk);
				@(negedge clk);
				checkValue(mixOut, mixModel(smp, vol), "saturated mix");
			end
			KIND_STEP: begin
				silenceAll();
				setupVoice(t.voice, t.base, t.freq, t.vol, t.lenLog2);
				watchSteps(t);
			end
			default: begin
				$display("Unknown test kind %0d in the stimulus table", t.kind);
				$display("Simulation failed");
				$fatal(1);
			end
		endcase
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		rst = 1'b1;
		hostWe = 1'b0;
		hostAddr = '0;
		hostData = '0;
		seed = 62;
		cycleLimit = runLimit();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		loadSamples();
		for (int i = 0; i < NUM_TESTS; i++)
			runEntry(TEST_TABLE[i]);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* psgWaveSys.f */
+incdir+testbench
rtl/psgBusPkg.sv
rtl/psgVoicePkg.sv
rtl/psgBusArb.sv
rtl/psgWaveVoice.sv
rtl/psgSampleMem.sv
rtl/psgRegs.sv
rtl/psgMixer.sv
rtl/psgWaveSys.sv
testbench/psgWaveSysTb.sv
